// ==== Makefile ====
TOP := sb_ctrl_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sb_ctrl_unit.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== dv/sb_ctrl_unit_patterns.txt ====
// inst imm unit op rd rs1 rs2 imm_sel, all hex
// unit 1 alu, 2 mem, 3 mul, 0 dropped word; op is the 5-bit unit op code
003100B3 00000000 1 00 01 02 03 0
02508233 00000000 3 00 04 01 05 0
00822303 00000008 2 04 06 04 00 1
40130433 00000000 1 01 08 06 01 0
02840533 00000000 3 00 0A 08 08 0
009505B3 00000000 1 00 0B 0A 09 0
00002483 00000000 2 04 09 00 00 1
00B4A623 0000000C 2 05 00 09 0B 2
12345637 12345000 1 1A 0C 00 00 3
024616B3 00000000 3 01 0D 0C 04 0
FFFFFFFF 00000000 0 00 00 00 00 0
0FF6C713 000000FF 1 15 0E 0D 00 1
40375793 00000403 1 17 0F 0E 00 1
02D7A833 00000000 3 02 10 0F 0D 0
0062E833 00000000 1 08 10 05 06 0
020838B3 00000000 3 03 11 10 00 0
FFC8C903 FFFFFFFC 2 08 12 11 00 1
FF201F23 FFFFFFFE 2 03 00 00 12 2
0220C9B3 00000000 0 00 00 00 00 0
011929B3 00000000 1 03 13 12 11 0

// ==== dv/sb_ctrl_unit_props.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module sb_ctrl_unit_props import sb_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  issue_en,
    input fu_id_e                dec_fu,
    input logic [`SB_REG_AW-1:0] dec_dst,
    input logic [`SB_REG_AW-1:0] dec_src1,
    input logic [`SB_REG_AW-1:0] dec_src2,
    input logic                  alu_en,
    input logic                  mem_en,
    input logic                  mul_en,
    input logic                  reg_write,
    input logic [`SB_REG_AW-1:0] rd,
    input fu_id_e                write_sel
);
    logic [`SB_NUM_REGS-1:0]    wr_pend;   // issued writer not yet written back
    logic [3:1]                 waiting;   // issued, operands not read yet
    logic [3:1]                 owe1;      // first source owed by an older writer
    logic [3:1]                 owe2;
    logic [3:1][`SB_REG_AW-1:0] rd_src1;
    logic [3:1][`SB_REG_AW-1:0] rd_src2;
    logic [3:1]                 en_vec;
    logic                       war_hit;   // a waiting reader still needs the old value of rd

    assign en_vec = {mul_en, mem_en, alu_en};

    // own view of issue order, built from issue and write-back only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_pend <= '0;
            waiting <= '0;
            owe1    <= '0;
            owe2    <= '0;
            rd_src1 <= '0;
            rd_src2 <= '0;
        end else begin
            if (reg_write)
                wr_pend[rd] <= 1'b0;
            for (int u = 1; u <= 3; u++) begin
                if (en_vec[u])
                    waiting[u] <= 1'b0;
                if (reg_write && rd_src1[u] == rd)
                    owe1[u] <= 1'b0;
                if (reg_write && rd_src2[u] == rd)
                    owe2[u] <= 1'b0;
            end
            if (issue_en && dec_fu != FU_NONE) begin
                waiting[dec_fu] <= 1'b1;
                rd_src1[dec_fu] <= dec_src1;
                rd_src2[dec_fu] <= dec_src2;
                owe1[dec_fu]    <= wr_pend[dec_src1] && !(reg_write && rd == dec_src1);
                owe2[dec_fu]    <= wr_pend[dec_src2] && !(reg_write && rd == dec_src2);
                if (dec_dst != '0)
                    wr_pend[dec_dst] <= 1'b1;
            end
        end
    end

    // a reader with no owed producer for r issued before the writer of r
    always_comb begin
        war_hit = 1'b0;
        for (int v = 1; v <= 3; v++) begin
            if (waiting[v] && rd != '0 &&
                ((rd_src1[v] == rd && !owe1[v]) || (rd_src2[v] == rd && !owe2[v])))
                war_hit = 1'b1;
        end
    end

    a_one_dispatch: assert property (@(posedge clk) disable iff (rst)
        $onehot0(en_vec) && (en_vec & ~waiting) == '0)
        else $error("enable without a single waiting instruction behind it");

    // operands only go out once every older producer has written back
    a_dispatch_ready: assert property (@(posedge clk) disable iff (rst)
        (en_vec & (owe1 | owe2)) == '0)
        else $error("dispatch before an older producer wrote back");

    a_write_back: assert property (@(posedge clk) disable iff (rst)
        reg_write |-> write_sel != FU_NONE && !waiting[write_sel] && !war_hit)
        else $error("write-back before dispatch or against a pending reader");

endmodule

bind sb_ctrl_unit sb_ctrl_unit_props u_props (
    .clk(clk), .rst(rst), .issue_en(issue_en), .dec_fu(dec_fu), .dec_dst(dec_dst),
    .dec_src1(dec_src1), .dec_src2(dec_src2), .alu_en(alu_en), .mem_en(mem_en),
    .mul_en(mul_en), .reg_write(reg_write), .rd(rd), .write_sel(write_sel)
);

// ==== dv/sb_ctrl_unit_tb.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module sb_ctrl_unit_tb import sb_pkg::*; ();
    localparam int NUM_REC = 20;
    localparam int CYCLE   = 100;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [`SB_XLEN-1:0]   inst;
    logic                  inst_valid;
    logic [`SB_XLEN-1:0]   imm;
    logic                  alu_done;
    logic                  mem_done;
    logic                  mul_done;
    logic                  inst_ready;
    imm_sel_e              imm_sel;
    logic                  alu_en;
    logic                  mem_en;
    logic                  mul_en;
    alu_op_e               alu_op;
    logic                  alu_use_imm;
    logic                  mem_we;
    logic [2:0]            mem_width;
    mul_op_e               mul_op;
    logic [`SB_REG_AW-1:0] rs1_sel;
    logic [`SB_REG_AW-1:0] rs2_sel;
    logic [`SB_XLEN-1:0]   imm_out;
    logic                  reg_write;
    logic [`SB_REG_AW-1:0] rd;
    fu_id_e                write_sel;

    logic [31:0] pat [0:NUM_REC*8-1];   // 8 words per record
    int          seed = 32'h4da2;
    int          pend [`SB_NUM_REGS];     // pending writer unit per register
    bit          ubusy [1:3];
    bit          dispatched [1:3];
    bit          done_seen [1:3];
    int          rec_of [1:3];            // record held by each unit
    int          owe1 [1:3];              // producer still owed, 0 when free
    int          owe2 [1:3];
    int          cnt [1:3];               // cycles left until done pulse

    sb_ctrl_unit UUT (.*);

    always #50 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic [31:0] rec_field(input int r, input int f);
        return pat[r * 8 + f];
    endfunction

    function automatic bit units_busy();
        return ubusy[1] || ubusy[2] || ubusy[3];
    endfunction

    // unit models, one done pulse per dispatch
    task automatic drive_units();
        logic [3:1] pulse;
        pulse = '0;
        for (int u = 1; u <= 3; u++) begin
            if (cnt[u] > 0) begin
                cnt[u]--;
                if (cnt[u] == 0) begin
                    pulse[u]     = 1'b1;
                    done_seen[u] = 1'b1;
                end
            end
        end
        {mul_done, mem_done, alu_done} = pulse;
    endtask

    task automatic observe_cycle(input int idx, output bit took);
        logic [3:1]            en_vec;
        logic [31:0]           got_op;
        logic [1:0]            exp_fu;
        logic [`SB_REG_AW-1:0] exp_rd;
        logic [1:0]            w;
        int                    r;
        en_vec = {mul_en, mem_en, alu_en};
        exp_fu = '0;
        exp_rd = '0;
        took   = inst_valid && inst_ready;
        if (inst_valid) begin
            exp_fu = 2'(rec_field(idx, 2));
            exp_rd = 5'(rec_field(idx, 4));
            // structural and waw stall from the model tables
            check_value(32'(inst_ready),
                        32'(exp_fu == 0 || (!ubusy[exp_fu] && pend[exp_rd] == 0)),
                        "inst_ready");
            if (inst_ready)
                check_value(32'(imm_sel), rec_field(idx, 7), "imm_sel at issue");
        end
        for (int u = 1; u <= 3; u++) begin
            if (en_vec[u]) begin
                r = rec_of[u];
                check_value(32'(ubusy[u] && !dispatched[u]), 1, "enable with nothing to dispatch");
                check_value(32'(owe1[u] == 0 && owe2[u] == 0), 1, "dispatch before producer write-back");
                case (u)
                    1:       got_op = 32'({alu_use_imm, alu_op});
                    2:       got_op = 32'({mem_width, mem_we});
                    default: got_op = 32'(mul_op);
                endcase
                check_value(got_op, rec_field(r, 3), "dispatched op");
                check_value(32'(rs1_sel), rec_field(r, 5), "rs1_sel");
                check_value(32'(rs2_sel), rec_field(r, 6), "rs2_sel");
                check_value(imm_out, rec_field(r, 1), "imm_out");
                dispatched[u] = 1'b1;
                cnt[u]        = 1 + int'($unsigned($random(seed)) % 6);
            end
        end
        if (reg_write) begin
            w = write_sel;
            check_value(32'(w != 0 && ubusy[w] && dispatched[w] && done_seen[w]), 1,
                        "write-back from a unit that has not finished");
            r = rec_of[w];
            check_value(32'(rd), rec_field(r, 4), "rd at write-back");
            for (int v = 1; v <= 3; v++) begin
                // war, older reader not yet dispatched
                if (v != w && ubusy[v] && !dispatched[v] && rec_of[v] < r && rd != '0 &&
                    (rec_field(rec_of[v], 5) == 32'(rd) || rec_field(rec_of[v], 6) == 32'(rd)))
                    check_value(32'(rd), 0, "write-back of a register an older reader needs");
                if (owe1[v] == w)
                    owe1[v] = 0;
                if (owe2[v] == w)
                    owe2[v] = 0;
            end
            if (pend[rd] == w)
                pend[rd] = 0;
            ubusy[w]     = 1'b0;
            done_seen[w] = 1'b0;
        end
        if (took && exp_fu != 0) begin   // same-edge write-back already applied
            ubusy[exp_fu]      = 1'b1;
            dispatched[exp_fu] = 1'b0;
            done_seen[exp_fu]  = 1'b0;
            rec_of[exp_fu]     = idx;
            owe1[exp_fu]       = pend[5'(rec_field(idx, 5))];
            owe2[exp_fu]       = pend[5'(rec_field(idx, 6))];
            if (exp_rd != '0)
                pend[exp_rd] = int'(exp_fu);
        end
    endtask

    initial begin
        int idx;
        bit took;
        idx        = 0;
        took       = 1'b0;
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        imm        = '0;
        alu_done   = 1'b0;
        mem_done   = 1'b0;
        mul_done   = 1'b0;
        $readmemh("dv/sb_ctrl_unit_patterns.txt", pat);
        repeat (10) @(posedge clk);
        #10 rst = 1'b0;
        @(negedge clk);
        check_value(32'({alu_en, mem_en, mul_en, reg_write}), 0, "activity after reset");
        while (idx < NUM_REC || units_busy()) begin
            @(posedge clk);
            #10;
            if (took)
                idx++;
            drive_units();
            inst_valid = idx < NUM_REC;
            if (idx < NUM_REC) begin   // held while stalled
                inst = rec_field(idx, 0);
                imm  = rec_field(idx, 1);
            end
            @(negedge clk);
            observe_cycle(idx, took);
        end
        $display("STATUS: PASS");
        $finish;
    end

    // watchdog
    initial begin
        #((NUM_REC * 40 + 10) * CYCLE);
        $display("Timeout: run did not finish within %0d cycles", NUM_REC * 40 + 10);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== logic/sb_config.svh ====
`ifndef SB_CONFIG_SVH
`define SB_CONFIG_SVH

// architectural register file
`define SB_NUM_REGS 32
`define SB_REG_AW   5

// data and immediate width
`define SB_XLEN     32

// 4-bit unit op code with the alu immediate flag on top
`define SB_OP_W     5

`endif

// ==== logic/sb_ctrl_unit.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module sb_ctrl_unit import sb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`SB_XLEN-1:0]   inst,
    input  logic                  inst_valid,
    input  logic [`SB_XLEN-1:0]   imm,
    input  logic                  alu_done,
    input  logic                  mem_done,
    input  logic                  mul_done,
    output logic                  inst_ready,
    output imm_sel_e              imm_sel,
    output logic                  alu_en,
    output logic                  mem_en,
    output logic                  mul_en,
    output alu_op_e               alu_op,
    output logic                  alu_use_imm,
    output logic                  mem_we,
    output logic [2:0]            mem_width,
    output mul_op_e               mul_op,
    output logic [`SB_REG_AW-1:0] rs1_sel,
    output logic [`SB_REG_AW-1:0] rs2_sel,
    output logic [`SB_XLEN-1:0]   imm_out,
    output logic                  reg_write,
    output logic [`SB_REG_AW-1:0] rd,
    output fu_id_e                write_sel
);
    fu_id_e                     dec_fu;
    logic [`SB_OP_W-1:0]        dec_op;
    logic [`SB_REG_AW-1:0]      dec_dst;
    logic [`SB_REG_AW-1:0]      dec_src1;
    logic [`SB_REG_AW-1:0]      dec_src2;
    logic                       known;
    fu_id_e                     fu1;
    fu_id_e                     fu2;
    logic                       dst_pending;
    logic                       unit_busy;
    logic                       issue_en;
    logic [3:1]                 busy;
    logic [3:1]                 rdy1;
    logic [3:1]                 rdy2;
    logic [3:1]                 done;
    logic [3:1][`SB_OP_W-1:0]   fu_op;
    logic [3:1][`SB_REG_AW-1:0] fu_dst;
    logic [3:1][`SB_REG_AW-1:0] fu_src1;
    logic [3:1][`SB_REG_AW-1:0] fu_src2;
    logic [3:1][`SB_XLEN-1:0]   fu_imm;
    fu_id_e                     ro_fu;
    fu_id_e                     wb_fu;

    sb_decoder u_dec (
        .inst(inst), .fu(dec_fu), .op(dec_op), .dst(dec_dst),
        .src1(dec_src1), .src2(dec_src2), .imm_sel(imm_sel), .known(known)
    );

    always_comb begin
        unit_busy = 1'b0;
        if (dec_fu != FU_NONE)
            unit_busy = busy[dec_fu];
    end

    // structural and waw stall, unknown words drain straight away
    assign inst_ready = !known || (!unit_busy && !dst_pending);
    assign issue_en   = inst_valid && inst_ready && known;

    sb_reg_status u_rrs (
        .clk(clk), .rst(rst),
        .set_en(issue_en), .set_reg(dec_dst), .set_fu(dec_fu),
        .clr_en(reg_write), .clr_reg(rd),
        .src1(dec_src1), .src2(dec_src2), .dst(dec_dst),
        .fu1(fu1), .fu2(fu2), .dst_pending(dst_pending)
    );

    sb_fu_status u_fus (
        .clk(clk), .rst(rst), .issue_en(issue_en), .issue_fu(dec_fu),
        .op(dec_op), .dst(dec_dst), .src1(dec_src1), .src2(dec_src2),
        .fu1(fu1), .fu2(fu2), .imm(imm), .ro_fu(ro_fu), .wb_fu(wb_fu),
        .alu_done(alu_done), .mem_done(mem_done), .mul_done(mul_done),
        .busy(busy), .rdy1(rdy1), .rdy2(rdy2), .done(done),
        .fu_op(fu_op), .fu_dst(fu_dst), .fu_src1(fu_src1), .fu_src2(fu_src2),
        .fu_imm(fu_imm)
    );

    sb_hazard_select u_hz (
        .busy(busy), .rdy1(rdy1), .rdy2(rdy2), .done(done),
        .dst(fu_dst), .src1(fu_src1), .src2(fu_src2),
        .ro_fu(ro_fu), .wb_fu(wb_fu)
    );

    // operand read and dispatch of the picked unit
    always_comb begin
        {alu_en, mem_en, mul_en} = 3'b000;
        alu_op      = ALU_ADD;
        alu_use_imm = 1'b0;
        mem_we      = 1'b0;
        mem_width   = 3'd0;
        mul_op      = MUL_MUL;
        rs1_sel     = '0;
        rs2_sel     = '0;
        imm_out     = '0;
        if (ro_fu != FU_NONE) begin
            rs1_sel = fu_src1[ro_fu];
            rs2_sel = fu_src2[ro_fu];
            imm_out = fu_imm[ro_fu];
        end
        case (ro_fu)
            FU_ALU: begin
                alu_en      = 1'b1;
                alu_op      = alu_op_e'(fu_op[FU_ALU][`SB_OP_W-2:0]);
                alu_use_imm = fu_op[FU_ALU][`SB_OP_W-1];
            end
            FU_MEM: begin
                mem_en    = 1'b1;
                mem_we    = fu_op[FU_MEM][0];
                mem_width = fu_op[FU_MEM][3:1];
            end
            FU_MUL: begin
                mul_en = 1'b1;
                mul_op = mul_op_e'(fu_op[FU_MUL][`SB_OP_W-2:0]);
            end
            default: ;
        endcase
    end

    // write-back
    always_comb begin
        rd = '0;
        if (wb_fu != FU_NONE)
            rd = fu_dst[wb_fu];
    end

    assign reg_write = wb_fu != FU_NONE;
    assign write_sel = wb_fu;

endmodule

// ==== logic/sb_decoder.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module sb_decoder import sb_pkg::*; (
    input  logic [`SB_XLEN-1:0]   inst,
    output fu_id_e                fu,
    output logic [`SB_OP_W-1:0]   op,
    output logic [`SB_REG_AW-1:0] dst,
    output logic [`SB_REG_AW-1:0] src1,
    output logic [`SB_REG_AW-1:0] src2,
    output imm_sel_e              imm_sel,
    output logic                  known
);
    logic [6:0]          funct7;
    logic [2:0]          funct3;
    logic                use_imm;   // alu immediate form
    logic [`SB_OP_W-2:0] code;
    logic                has_rd;
    logic                has_rs1;
    logic                has_rs2;

    function automatic alu_op_e alu_code(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    alu_code = alt ? ALU_SUB : ALU_ADD;
            3'd1:    alu_code = ALU_SLL;
            3'd2:    alu_code = ALU_SLT;
            3'd3:    alu_code = ALU_SLTU;
            3'd4:    alu_code = ALU_XOR;
            3'd5:    alu_code = alt ? ALU_SRA : ALU_SRL;
            3'd6:    alu_code = ALU_OR;
            default: alu_code = ALU_AND;
        endcase
    endfunction

    assign funct7 = inst[31:25];
    assign funct3 = inst[14:12];

    always_comb begin
        fu      = FU_NONE;
        code    = '0;
        use_imm = 1'b0;
        imm_sel = IMM_NONE;
        known   = 1'b0;
        has_rd  = 1'b0;
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        case (inst[6:0])
            OP_R: begin
                {has_rd, has_rs1, has_rs2} = 3'b111;
                if (funct7 == 7'h01) begin
                    fu    = FU_MUL;
                    code  = {2'b00, funct3[1:0]};   // mul group lives in funct3 0..3
                    known = !funct3[2];
                end else begin
                    fu    = FU_ALU;
                    code  = alu_code(funct3, funct7[5]);
                    known = (funct7 == 7'h00) ||
                            (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5));
                end
            end
            OP_IMM: begin
                {has_rd, has_rs1} = 2'b11;
                fu      = FU_ALU;
                use_imm = 1'b1;
                imm_sel = IMM_I;
                code    = alu_code(funct3, funct3 == 3'd5 && funct7[5]);
                // shift amounts only allow funct7 of 0, or 0x20 for srai
                if (funct3 == 3'd1)
                    known = funct7 == 7'h00;
                else if (funct3 == 3'd5)
                    known = funct7 == 7'h00 || funct7 == 7'h20;
                else
                    known = 1'b1;
            end
            OP_LOAD: begin
                {has_rd, has_rs1} = 2'b11;
                fu      = FU_MEM;
                imm_sel = IMM_I;
                code    = {funct3, 1'b0};
                known   = funct3 != 3'd3 && funct3[2:1] != 2'b11;
            end
            OP_STORE: begin
                {has_rs1, has_rs2} = 2'b11;
                fu      = FU_MEM;
                imm_sel = IMM_S;
                code    = {funct3, 1'b1};
                known   = !funct3[2] && funct3 != 3'd3;
            end
            OP_LUI: begin
                has_rd  = 1'b1;
                fu      = FU_ALU;
                use_imm = 1'b1;
                imm_sel = IMM_U;
                code    = ALU_LUI;
                known   = 1'b1;
            end
            default: ;
        endcase
        if (!known) begin   // dropped instruction, nothing reaches the tables
            fu      = FU_NONE;
            code    = '0;
            use_imm = 1'b0;
            imm_sel = IMM_NONE;
            {has_rd, has_rs1, has_rs2} = 3'b000;
        end
    end

    assign op   = {use_imm, code};
    assign dst  = has_rd  ? inst[11:7]  : '0;
    assign src1 = has_rs1 ? inst[19:15] : '0;
    assign src2 = has_rs2 ? inst[24:20] : '0;

endmodule

// ==== logic/sb_fu_status.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module sb_fu_status import sb_pkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           issue_en,
    input  fu_id_e                         issue_fu,
    input  logic [`SB_OP_W-1:0]            op,
    input  logic [`SB_REG_AW-1:0]          dst,
    input  logic [`SB_REG_AW-1:0]          src1,
    input  logic [`SB_REG_AW-1:0]          src2,
    input  fu_id_e                         fu1,
    input  fu_id_e                         fu2,
    input  logic [`SB_XLEN-1:0]            imm,
    input  fu_id_e                         ro_fu,
    input  fu_id_e                         wb_fu,
    input  logic                           alu_done,
    input  logic                           mem_done,
    input  logic                           mul_done,
    output logic [3:1]                     busy,
    output logic [3:1]                     rdy1,
    output logic [3:1]                     rdy2,
    output logic [3:1]                     done,
    output logic [3:1][`SB_OP_W-1:0]       fu_op,
    output logic [3:1][`SB_REG_AW-1:0]     fu_dst,
    output logic [3:1][`SB_REG_AW-1:0]     fu_src1,
    output logic [3:1][`SB_REG_AW-1:0]     fu_src2,
    output logic [3:1][`SB_XLEN-1:0]       fu_imm
);
    fu_id_e     tag1 [1:3];   // producer still owed, FU_NONE once woken
    fu_id_e     tag2 [1:3];
    logic [3:1] done_in;
    logic       wake1;
    logic       wake2;

    assign done_in = {mul_done, mem_done, alu_done};

    // a producer writing back on the issue edge counts as already done
    assign wake1 = fu1 == FU_NONE || fu1 == wb_fu;
    assign wake2 = fu2 == FU_NONE || fu2 == wb_fu;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
            done <= '0;
            for (int u = 1; u <= 3; u++) begin
                tag1[u] <= FU_NONE;
                tag2[u] <= FU_NONE;
            end
        end else begin
            for (int u = 1; u <= 3; u++) begin
                if (ro_fu == fu_id_e'(u)) begin   // operands read this cycle
                    rdy1[u] <= 1'b0;
                    rdy2[u] <= 1'b0;
                end
                if (wb_fu != FU_NONE && tag1[u] == wb_fu) begin
                    rdy1[u] <= 1'b1;
                    tag1[u] <= FU_NONE;
                end
                if (wb_fu != FU_NONE && tag2[u] == wb_fu) begin
                    rdy2[u] <= 1'b1;
                    tag2[u] <= FU_NONE;
                end
                if (done_in[u])
                    done[u] <= 1'b1;
                if (wb_fu == fu_id_e'(u)) begin
                    busy[u] <= 1'b0;
                    done[u] <= 1'b0;
                end
                if (issue_en && issue_fu == fu_id_e'(u)) begin
                    busy[u] <= 1'b1;
                    done[u] <= 1'b0;
                    rdy1[u] <= wake1;
                    rdy2[u] <= wake2;
                    tag1[u] <= wake1 ? FU_NONE : fu1;
                    tag2[u] <= wake2 ? FU_NONE : fu2;
                end
            end
        end
    end

    // payload, only meaningful while busy
    always_ff @(posedge clk) begin
        for (int u = 1; u <= 3; u++) begin
            if (issue_en && issue_fu == fu_id_e'(u)) begin
                fu_op[u]   <= op;
                fu_dst[u]  <= dst;
                fu_src1[u] <= src1;
                fu_src2[u] <= src2;
                fu_imm[u]  <= imm;
            end
        end
    end

endmodule

// ==== logic/sb_hazard_select.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module sb_hazard_select import sb_pkg::*; (
    input  logic [3:1]                 busy,
    input  logic [3:1]                 rdy1,
    input  logic [3:1]                 rdy2,
    input  logic [3:1]                 done,
    input  logic [3:1][`SB_REG_AW-1:0] dst,
    input  logic [3:1][`SB_REG_AW-1:0] src1,
    input  logic [3:1][`SB_REG_AW-1:0] src2,
    output fu_id_e                     ro_fu,
    output fu_id_e                     wb_fu
);
    logic [3:1] war_ok;   // nobody still has to read this unit's dst
    logic [3:1] ro_req;
    logic [3:1] wb_req;

    // a reader with its ready flag up has not fetched the old value yet
    always_comb begin
        for (int u = 1; u <= 3; u++) begin
            war_ok[u] = 1'b1;
            for (int v = 1; v <= 3; v++) begin
                if (v != u && busy[v] && dst[u] != '0 &&
                    ((rdy1[v] && src1[v] == dst[u]) ||
                     (rdy2[v] && src2[v] == dst[u])))
                    war_ok[u] = 1'b0;
            end
        end
    end

    assign ro_req = busy & rdy1 & rdy2;
    assign wb_req = done & war_ok;

    // walk from mul down so alu ends up on top
    always_comb begin
        ro_fu = FU_NONE;
        wb_fu = FU_NONE;
        for (int u = 3; u >= 1; u--) begin
            if (ro_req[u])
                ro_fu = fu_id_e'(u);
            if (wb_req[u])
                wb_fu = fu_id_e'(u);
        end
    end

endmodule

// ==== logic/sb_pkg.sv ====
package sb_pkg;

    // unit tags, FU_NONE doubles as "no producer" and "no pick"
    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        FU_ALU  = 2'd1,
        FU_MEM  = 2'd2,
        FU_MUL  = 2'd3
    } fu_id_e;

    typedef enum logic [6:0] {
        OP_R     = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011,
        OP_LUI   = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
    } alu_op_e;

    // bit 0 is write, bits 3:1 are funct3 width code
    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0010,
        MEM_LW  = 4'b0100,
        MEM_LBU = 4'b1000,
        MEM_LHU = 4'b1010,
        MEM_SB  = 4'b0001,
        MEM_SH  = 4'b0011,
        MEM_SW  = 4'b0101
    } mem_op_e;

    typedef enum logic [3:0] {
        MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU
    } mul_op_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_U
    } imm_sel_e;

endpackage

// ==== logic/sb_reg_status.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module sb_reg_status import sb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  set_en,
    input  logic [`SB_REG_AW-1:0] set_reg,
    input  fu_id_e                set_fu,
    input  logic                  clr_en,
    input  logic [`SB_REG_AW-1:0] clr_reg,
    input  logic [`SB_REG_AW-1:0] src1,
    input  logic [`SB_REG_AW-1:0] src2,
    input  logic [`SB_REG_AW-1:0] dst,
    output fu_id_e                fu1,
    output fu_id_e                fu2,
    output logic                  dst_pending
);
    fu_id_e rrs [`SB_NUM_REGS];   // pending writer per register

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `SB_NUM_REGS; r++)
                rrs[r] <= FU_NONE;
        end else begin
            if (clr_en)
                rrs[clr_reg] <= FU_NONE;
            // later assignment, so a same-edge set overrides the clear
            if (set_en && set_reg != '0)
                rrs[set_reg] <= set_fu;
        end
    end

    // x0 is never recorded so it always reads as free
    assign fu1         = rrs[src1];
    assign fu2         = rrs[src2];
    assign dst_pending = rrs[dst] != FU_NONE;

endmodule

// ==== sb_ctrl_unit.f ====
+incdir+logic
logic/sb_pkg.sv
logic/sb_decoder.sv
logic/sb_reg_status.sv
logic/sb_fu_status.sv
logic/sb_hazard_select.sv
logic/sb_ctrl_unit.sv
dv/sb_ctrl_unit_props.sv
dv/sb_ctrl_unit_tb.sv
